//--- include/lanzones_defs.svh
`ifndef LANZONES_DEFS_SVH
`define LANZONES_DEFS_SVH

// data path and bus address width
`define LZ_XLEN 32

// register file geometry
`define LZ_NREGS 32
`define LZ_REGW 5

// word address of the first fetch after reset
`define LZ_START_PC 32'd0

// stops the sequencer until the next load pulse
`define LZ_OP_HALT 7'h7F

// RV32 base opcodes that the core executes
`define LZ_OP_LUI 7'b0110111
`define LZ_OP_ADD 7'b0110011
`define LZ_OP_SW 7'b0100011
`define LZ_OP_LW 7'b0000011

`endif

//--- logic/lanzonesPkg.sv
`default_nettype none

package lanzonesPkg;

`include "lanzones_defs.svh"

   typedef enum logic [6:0] {
      OP_LUI  = `LZ_OP_LUI,
      OP_ADD  = `LZ_OP_ADD,
      OP_SW   = `LZ_OP_SW,
      OP_LW   = `LZ_OP_LW,
      OP_HALT = `LZ_OP_HALT
   } opcode_e;

   typedef enum logic [1:0] {
      SEQ_HALTED,
      SEQ_FETCH,
      SEQ_EXEC,
      SEQ_MEMWAIT
   } seqState_e;

   // one bus access, also the form of the core's bus output
   typedef struct packed {
      logic req;
      logic we;
      logic [`LZ_XLEN-1:0] addr;
      logic [`LZ_XLEN-1:0] wdata;
   } memReq_t;

   typedef struct packed {
      logic en;
      logic [`LZ_REGW-1:0] addr;
      logic [`LZ_XLEN-1:0] data;
   } regWrite_t;

   // load or store handed from exec to the bus side
   typedef struct packed {
      logic valid;
      logic isStore;
      logic [`LZ_REGW-1:0] rd; // load destination
      logic [`LZ_XLEN-1:0] addr;
      logic [`LZ_XLEN-1:0] wdata;
   } dataAccess_t;

endpackage

`default_nettype wire

//--- logic/regFile.sv
`timescale 1ns/100ps
`default_nettype none

`include "lanzones_defs.svh"

module regFile (
   input wire clk,
   input wire rstn,
   input wire [`LZ_REGW-1:0] rs1,
   input wire [`LZ_REGW-1:0] rs2,
   output logic [`LZ_XLEN-1:0] rdata1,
   output logic [`LZ_XLEN-1:0] rdata2,
   input wire lanzonesPkg::regWrite_t execWrite,
   input wire lanzonesPkg::regWrite_t loadWrite
);

   import lanzonesPkg::*;

   // x0 has no storage
   logic [`LZ_XLEN-1:0] regs [1:`LZ_NREGS-1];
   regWrite_t wr;

   // the two ports are never active together
   assign wr = execWrite.en ? execWrite : loadWrite;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 1; i < `LZ_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr.en && (wr.addr != '0)) begin
         regs[wr.addr] <= wr.data;
      end
   end

   assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
   assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- logic/execUnit.sv
`timescale 1ns/100ps
`default_nettype none

`include "lanzones_defs.svh"

module execUnit (
   input wire [`LZ_XLEN-1:0] instr,
   input wire instrVld,
   input wire [`LZ_XLEN-1:0] rdata1,
   input wire [`LZ_XLEN-1:0] rdata2,
   output logic [`LZ_REGW-1:0] rs1,
   output logic [`LZ_REGW-1:0] rs2,
   output lanzonesPkg::regWrite_t execWrite,
   output lanzonesPkg::dataAccess_t access,
   output logic haltOp
);

   import lanzonesPkg::*;

   opcode_e op;
   logic [`LZ_REGW-1:0] rd;
   logic [19:0] immU;
   logic [11:0] immI;
   logic [11:0] immS;
   logic isLui;
   logic isAdd;
   logic isSw;
   logic isLw;
   logic isHalt;
   logic [`LZ_XLEN-1:0] offset;
   logic [`LZ_XLEN-1:0] aluB;
   logic [`LZ_XLEN-1:0] aluOut;

   // field extraction
   assign op = opcode_e'(instr[6:0]);
   assign rd = instr[11:7];
   assign rs1 = instr[19:15];
   assign rs2 = instr[24:20];
   assign immU = instr[31:12];
   assign immI = instr[31:20];
   assign immS = {instr[31:25], instr[11:7]};

   always_comb begin
      isLui = 1'b0;
      isAdd = 1'b0;
      isSw = 1'b0;
      isLw = 1'b0;
      isHalt = 1'b0;
      case (op)
         OP_LUI: isLui = 1'b1;
         OP_ADD: isAdd = 1'b1;
         OP_SW: isSw = 1'b1;
         OP_LW: isLw = 1'b1;
         OP_HALT: isHalt = 1'b1;
         default: ; // anything else is a no-op
      endcase
   end

   // sign-extended load/store offset
   assign offset = isSw ? {{(`LZ_XLEN-12){immS[11]}}, immS}
                        : {{(`LZ_XLEN-12){immI[11]}}, immI};

   // ALU
   assign aluB = isAdd ? rdata2 : offset;
   assign aluOut = rdata1 + aluB;

   assign execWrite.en = instrVld & (isLui | isAdd);
   assign execWrite.addr = rd;
   assign execWrite.data = isLui ? {immU, 12'b0} : aluOut;

   assign access.valid = instrVld & (isSw | isLw);
   assign access.isStore = isSw;
   assign access.rd = rd;
   assign access.addr = aluOut;
   assign access.wdata = rdata2; // store data from rs2

   assign haltOp = instrVld & isHalt;

endmodule

`default_nettype wire

//--- logic/fetchUnit.sv
`timescale 1ns/100ps
`default_nettype none

`include "lanzones_defs.svh"

module fetchUnit (
   input wire clk,
   input wire rstn,
   input wire loadEn,
   input wire fetchDone,
   input wire [`LZ_XLEN-1:0] fetchRData,
   input wire lanzonesPkg::dataAccess_t access,
   input wire haltOp,
   input wire dataDone,
   output lanzonesPkg::memReq_t fetchReq,
   output logic [`LZ_XLEN-1:0] instr,
   output logic instrVld,
   output logic halt
);

   import lanzonesPkg::*;

   seqState_e state;
   logic [`LZ_XLEN-1:0] pc;
   logic [`LZ_XLEN-1:0] instrQ;

   // sequencer, pc and halt flag
   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= SEQ_HALTED;
         pc <= `LZ_START_PC;
         halt <= 1'b1;
      end else begin
         case (state)
            SEQ_HALTED: begin
               if (loadEn) begin
                  state <= SEQ_FETCH;
                  halt <= 1'b0;
               end
            end
            SEQ_FETCH: begin
               if (fetchDone) begin
                  state <= SEQ_EXEC;
                  pc <= pc + 1'b1; // word addressed
               end
            end
            SEQ_EXEC: begin
               if (haltOp) begin
                  state <= SEQ_HALTED;
                  halt <= 1'b1;
               end else if (access.valid) begin
                  state <= SEQ_MEMWAIT;
               end else begin
                  state <= SEQ_FETCH;
               end
            end
            SEQ_MEMWAIT: begin
               if (dataDone) begin
                  state <= SEQ_FETCH;
               end
            end
            default: state <= SEQ_HALTED;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (fetchDone) begin
         instrQ <= fetchRData;
      end
   end

   // level request for the whole fetch state
   assign fetchReq = '{req: (state == SEQ_FETCH), we: 1'b0, addr: pc, wdata: '0};

   assign instr = instrQ;
   assign instrVld = (state == SEQ_EXEC); // one cycle per instruction

endmodule

`default_nettype wire

//--- logic/memPort.sv
`timescale 1ns/100ps
`default_nettype none

`include "lanzones_defs.svh"

module memPort (
   input wire clk,
   input wire rstn,
   input wire lanzonesPkg::memReq_t fetchReq,
   input wire lanzonesPkg::dataAccess_t access,
   output lanzonesPkg::memReq_t mem,
   input wire memVld,
   input wire [`LZ_XLEN-1:0] memRData,
   output logic fetchDone,
   output logic dataDone,
   output lanzonesPkg::regWrite_t loadWrite
);

   logic reqQ;
   logic weQ;
   logic isDataQ; // current access came from exec
   logic [`LZ_XLEN-1:0] addrQ;
   logic [`LZ_XLEN-1:0] wdataQ;
   logic [`LZ_REGW-1:0] rdQ;
   logic accessEnd;

   assign accessEnd = reqQ & memVld;

   // request state, new access only from idle
   always_ff @(posedge clk) begin
      if (!rstn) begin
         reqQ <= 1'b0;
         weQ <= 1'b0;
         isDataQ <= 1'b0;
      end else if (reqQ) begin
         if (memVld) begin
            reqQ <= 1'b0;
            weQ <= 1'b0;
         end
      end else if (access.valid) begin
         reqQ <= 1'b1;
         weQ <= access.isStore;
         isDataQ <= 1'b1;
      end else if (fetchReq.req) begin
         reqQ <= 1'b1;
         weQ <= fetchReq.we;
         isDataQ <= 1'b0;
      end
   end

   // address and data held steady while req is up
   always_ff @(posedge clk) begin
      if (!reqQ) begin
         if (access.valid) begin
            addrQ <= access.addr;
            wdataQ <= access.wdata;
            rdQ <= access.rd;
         end else begin
            addrQ <= fetchReq.addr;
            wdataQ <= fetchReq.wdata;
         end
      end
   end

   assign mem = '{req: reqQ, we: weQ, addr: addrQ, wdata: wdataQ};

   assign fetchDone = accessEnd & ~isDataQ;
   assign dataDone = accessEnd & isDataQ;

   // load completes in the memVld cycle
   assign loadWrite = '{en: dataDone & ~weQ, addr: rdQ, data: memRData};

endmodule

`default_nettype wire

//--- logic/lanzonesCore.sv
`timescale 1ns/100ps
`default_nettype none

`include "lanzones_defs.svh"

module lanzonesCore (
   input wire clk,
   input wire rstn,
   input wire loadEn,
   output logic halt,
   output lanzonesPkg::memReq_t mem,
   input wire memVld,
   input wire [`LZ_XLEN-1:0] memRData
);

   import lanzonesPkg::*;

   memReq_t fetchReq;
   dataAccess_t access;
   regWrite_t execWrite;
   regWrite_t loadWrite;
   logic [`LZ_XLEN-1:0] instr;
   logic instrVld;
   logic haltOp;
   logic fetchDone;
   logic dataDone;
   logic [`LZ_REGW-1:0] rs1;
   logic [`LZ_REGW-1:0] rs2;
   logic [`LZ_XLEN-1:0] rdata1;
   logic [`LZ_XLEN-1:0] rdata2;

   fetchUnit u_fetch (
      .clk(clk), .rstn(rstn), .loadEn(loadEn),
      .fetchDone(fetchDone), .fetchRData(memRData), // instruction word straight off the bus
      .access(access), .haltOp(haltOp), .dataDone(dataDone),
      .fetchReq(fetchReq), .instr(instr), .instrVld(instrVld), .halt(halt)
   );

   execUnit u_exec (
      .instr(instr), .instrVld(instrVld),
      .rdata1(rdata1), .rdata2(rdata2), .rs1(rs1), .rs2(rs2),
      .execWrite(execWrite), .access(access), .haltOp(haltOp)
   );

   regFile u_regs (
      .clk(clk), .rstn(rstn),
      .rs1(rs1), .rs2(rs2), .rdata1(rdata1), .rdata2(rdata2),
      .execWrite(execWrite), .loadWrite(loadWrite)
   );

   memPort u_mem (
      .clk(clk), .rstn(rstn),
      .fetchReq(fetchReq), .access(access),
      .mem(mem), .memVld(memVld), .memRData(memRData),
      .fetchDone(fetchDone), .dataDone(dataDone), .loadWrite(loadWrite)
   );

endmodule

`default_nettype wire

//--- verification/tbLanzones.sv
`timescale 1ns/100ps
`default_nettype none

`include "lanzones_defs.svh"

module tbLanzones;

   import lanzonesPkg::*;

   logic clk = 1'b0;
   logic rstn;
   logic loadEn;
   logic halt;
   memReq_t busReq;
   logic memVld;
   logic [`LZ_XLEN-1:0] memRData;

   logic [`LZ_XLEN-1:0] memArr [0:255]; // word addressed, low 8 bits used
   memReq_t gotStores [$];
   memReq_t expStores [$];
   logic [31:0] rngState;
   logic busy;
   int waitCnt;
   int errCount;
   int checkCount;
   int testCount;
   int failCount;
   logic aborted;

   lanzonesCore dut0 (
      .clk(clk), .rstn(rstn), .loadEn(loadEn), .halt(halt),
      .mem(busReq), .memVld(memVld), .memRData(memRData)
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic serveAccess();
      if (busReq.we) begin
         memArr[busReq.addr[7:0]] = busReq.wdata;
         gotStores.push_back(busReq);
         memRData = '0;
      end else begin
         memRData = memArr[busReq.addr[7:0]];
      end
      memVld = 1'b1;
   endtask

   // memory model, 0 to 3 idle cycles before each valid pulse
   always @(negedge clk) begin
      memVld = 1'b0;
      if (!rstn) begin
         busy = 1'b0;
      end else begin
         if (!busy && busReq.req) begin
            rngState = xorshift32(rngState);
            waitCnt = rngState[1:0];
            busy = 1'b1;
         end
         if (busy) begin
            if (waitCnt == 0) begin
               serveAccess();
               busy = 1'b0;
            end else begin
               waitCnt--;
            end
         end
      end
   end

   task automatic checkStore(input string name, input memReq_t exp, input memReq_t act);
      checkCount++;
      if (act !== exp) begin
         errCount++;
         $display("Error %s: store expected addr %h data %h, got addr %h data %h",
                  name, exp.addr, exp.wdata, act.addr, act.wdata);
      end
   endtask

   task automatic checkFetch(input string name, input memReq_t exp, input memReq_t act);
      checkCount++;
      if ({act.req, act.we, act.addr} !== {exp.req, exp.we, exp.addr}) begin
         errCount++;
         $display("Error %s: fetch expected req %b we %b addr %h, got req %b we %b addr %h",
                  name, exp.req, exp.we, exp.addr, act.req, act.we, act.addr);
      end
   endtask

   task automatic checkHalt(input string name, input logic exp, input logic act);
      checkCount++;
      if (act !== exp) begin
         errCount++;
         $display("Error %s: halt expected %b, got %b", name, exp, act);
      end
   endtask

   // bus must stay idle while halted
   task automatic checkQuiet(input string name, input int cycles);
      int i;
      logic seen;
      seen = 1'b0;
      checkCount++;
      for (i = 0; i < cycles && !seen; i++) begin
         @(negedge clk);
         if (busReq.req !== 1'b0) begin
            seen = 1'b1;
            errCount++;
            $display("%s: bus request to %h made while the core was halted", name, busReq.addr);
         end
      end
   endtask

   task automatic pulseLoad();
      loadEn = 1'b1;
      @(negedge clk);
      loadEn = 1'b0;
   endtask

   task automatic waitForRequest(input string name);
      int cnt;
      cnt = 0;
      while (busReq.req !== 1'b1 && cnt < 50) begin
         @(negedge clk);
         cnt++;
      end
      if (busReq.req !== 1'b1) begin
         errCount++;
         aborted = 1'b1;
         $display("%s: no fetch request within 50 cycles after the load pulse", name);
      end
   endtask

   task automatic waitForHalt(input string name);
      int cnt;
      cnt = 0;
      while (halt !== 1'b1 && cnt < 2000) begin
         @(negedge clk);
         cnt++;
      end
      if (halt !== 1'b1) begin
         errCount++;
         aborted = 1'b1;
         $display("%s: core did not halt within 2000 cycles", name);
      end
   endtask

   task automatic runTest(input string name, input logic [31:0] entry, input int quietCycles);
      int errBefore;
      int n;
      int i;
      memReq_t expFetch;
      errBefore = errCount;
      testCount++;
      if (aborted) begin
         $display("%s skipped after an earlier timeout", name);
         return;
      end
      checkQuiet(name, quietCycles);
      checkHalt(name, 1'b1, halt); // still halted after the idle window
      gotStores.delete();
      pulseLoad();
      checkHalt(name, 1'b0, halt);
      waitForRequest(name);
      if (!aborted) begin
         expFetch = '{req: 1'b1, we: 1'b0, addr: entry, wdata: '0};
         checkFetch(name, expFetch, busReq); // resumes at the entry word
         waitForHalt(name);
      end
      if (!aborted) begin
         if (gotStores.size() != expStores.size()) begin
            errCount++;
            $display("Error %s: store count expected %0d, got %0d",
                     name, expStores.size(), gotStores.size());
         end
         n = (gotStores.size() < expStores.size()) ? gotStores.size() : expStores.size();
         for (i = 0; i < n; i++) begin
            checkStore(name, expStores[i], gotStores[i]); // program order
         end
      end
      if (errCount == errBefore) begin
         $display("%s passed", name);
      end else begin
         failCount++;
         $display("%s failed with %0d errors", name, errCount - errBefore);
      end
   endtask

   initial begin
      int fd;
      int n;
      int quiet;
      string line;
      string tag;
      string curName;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] entry;
      logic haveEntry;
      memReq_t expReq;
      rstn = 1'b0;
      loadEn = 1'b0;
      memVld = 1'b0;
      memRData = '0;
      rngState = 32'h5a97;
      busy = 1'b0;
      waitCnt = 0;
      errCount = 0;
      checkCount = 0;
      testCount = 0;
      failCount = 0;
      aborted = 1'b0;
      entry = '0;
      haveEntry = 1'b0;
      for (int i = 0; i < 256; i++) begin
         memArr[i] = 32'hd1ce0000 + i;
      end
      fd = $fopen("verification/progTrace.txt", "r");
      if (fd == 0) begin
         errCount++;
         $display("cannot open verification/progTrace.txt");
      end
      repeat (3) @(negedge clk);
      rstn = 1'b1;
      curName = "";
      quiet = 20; // first window right after reset
      while (fd != 0 && $fgets(line, fd) > 0) begin
         n = $sscanf(line, "%s", tag);
         if (n != 1 || tag.substr(0, 0) == "#") begin
            continue;
         end
         if (tag == "T") begin
            if (curName != "") begin
               runTest(curName, entry, quiet);
               quiet = 30;
            end
            n = $sscanf(line, "%s %s", tag, curName);
            expStores.delete();
            haveEntry = 1'b0;
         end else if (tag == "P") begin
            n = $sscanf(line, "%s %h %h", tag, a, d);
            memArr[a[7:0]] = d;
            if (!haveEntry) begin
               entry = a;
               haveEntry = 1'b1;
            end
         end else if (tag == "S") begin
            n = $sscanf(line, "%s %h %h", tag, a, d);
            expReq = '{req: 1'b1, we: 1'b1, addr: a, wdata: d};
            expStores.push_back(expReq);
         end else begin
            errCount++;
            $display("trace line not understood: %s", line);
         end
      end
      if (curName != "") begin
         runTest(curName, entry, quiet);
      end
      if (fd != 0) begin
         $fclose(fd);
      end
      if (testCount == 0) begin
         errCount++;
         $display("no tests were found in the trace");
      end
      $display("summary %0d tests, %0d failed, %0d checks, %0d errors",
               testCount, failCount, checkCount, errCount);
      if (errCount == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verification/progTrace.txt
# T starts a test by name, P loads a word at a word address (first P is the entry)
# S gives one expected store as word address and data, in program order

T reset_start
P 00 00000013 # nop
P 01 0000007f # halt

T lui_add
P 02 123450b7 # lui x1, 0x12345
P 03 abcde137 # lui x2, 0xabcde
P 04 002081b3 # add x3, x1, x2
P 05 0c102023 # sw x1, 0xc0(x0)
P 06 0c3020a3 # sw x3, 0xc1(x0)
P 07 00318233 # add x4, x3, x3
P 08 0c402123 # sw x4, 0xc2(x0)
P 09 0000007f # halt
S c0 12345000
S c1 be023000
S c2 7c046000

T load_store
P 0a 08002283 # lw x5, 0x80(x0)
P 0b 08102383 # lw x7, 0x81(x0)
P 0c fe53ac23 # sw x5, -8(x7)
P 0d ff03a403 # lw x8, -16(x7)
P 0e fe83aca3 # sw x8, -7(x7)
P 0f 007284b3 # add x9, x5, x7
P 10 0c902523 # sw x9, 0xca(x0)
P 11 0000007f # halt
# data words
P 80 cafef00d
P 81 000000d0
S c8 cafef00d
S c9 12345000
S ca cafef0dd

T x0_write
P 12 00208033 # add x0, x1, x2
P 13 0c0025a3 # sw x0, 0xcb(x0)
P 14 fffff037 # lui x0, 0xfffff
P 15 00100533 # add x10, x0, x1
P 16 0ca02623 # sw x10, 0xcc(x0)
P 17 0000007f # halt
S cb 00000000
S cc 12345000

T halt_resume
P 18 00000013 # nop
P 19 0000007f # halt

# entry is one past the previous halt
T resume_state
P 1a 0c3026a3 # sw x3, 0xcd(x0)
P 1b 0000007f # halt
S cd be023000

//--- tb.f
+incdir+include
logic/lanzonesPkg.sv
logic/regFile.sv
logic/execUnit.sv
logic/fetchUnit.sv
logic/memPort.sv
logic/lanzonesCore.sv
verification/tbLanzones.sv

//--- Bender.yml
package:
  name: lanzones

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/lanzonesPkg.sv
      - logic/regFile.sv
      - logic/execUnit.sv
      - logic/fetchUnit.sv
      - logic/memPort.sv
      - logic/lanzonesCore.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tbLanzones.sv
